//--- io_bridge_consts.svh
`ifndef IO_BRIDGE_CONSTS_SVH
`define IO_BRIDGE_CONSTS_SVH

// Data path sizes
`define IO_BYTE_W       8
`define IO_BLOCK_BYTES  16

// Codes the host drives on to_hw_sig
`define HOST_IDLE   2'd0
`define HOST_MSG    2'd1
`define HOST_KEY    2'd2
`define HOST_START  2'd3

// Codes the hardware drives on to_sw_sig
`define HW_IDLE   2'd0
`define HW_BUSY   2'd1
`define HW_DONE   2'd2
`define HW_RESET  2'd3

// Two-bit flag field width shared by both directions
`define IO_FLAG_W  2

`endif

//--- io_bridge_pkg.sv
`include "io_bridge_consts.svh"

package io_bridge_pkg;

  // One transfer unit on the host ports
  typedef logic [`IO_BYTE_W-1:0] byte_t;

  // Index 15 holds the first byte on the wire, i.e. the MSB
  typedef byte_t [`IO_BLOCK_BYTES-1:0] block_t;

  typedef logic [$clog2(`IO_BLOCK_BYTES)-1:0] byte_idx_t;

  // HOST_MSG and HOST_KEY swap meaning during key loading
  typedef enum logic [`IO_FLAG_W-1:0] {
    HOST_IDLE  = `HOST_IDLE,
    HOST_MSG   = `HOST_MSG,
    HOST_KEY   = `HOST_KEY,
    HOST_START = `HOST_START
  } host_flag_t;

  typedef enum logic [`IO_FLAG_W-1:0] {
    HW_IDLE  = `HW_IDLE,
    HW_BUSY  = `HW_BUSY,
    HW_DONE  = `HW_DONE,
    HW_RESET = `HW_RESET
  } hw_flag_t;

  // Destination register for an incoming byte
  typedef enum logic {
    TGT_MSG = 1'b0,
    TGT_KEY = 1'b1
  } buf_target_t;

  typedef struct packed {
    logic        en;
    buf_target_t target;
    byte_idx_t   idx;
    byte_t       data;
  } byte_wr_t;

endpackage

//--- host_link_ctrl.sv
`timescale 1ns/1ns
`include "io_bridge_consts.svh"

module host_link_ctrl (
  input  logic                      clk,
  input  logic                      reset_n,
  input  io_bridge_pkg::host_flag_t to_hw_sig,
  input  io_bridge_pkg::byte_t      to_hw_port,
  input  logic                      aes_ready,
  output io_bridge_pkg::hw_flag_t   to_sw_sig,
  output logic                      io_ready,
  output io_bridge_pkg::byte_wr_t   byte_wr,
  output logic                      result_capture,
  output io_bridge_pkg::byte_idx_t  rd_idx,
  output logic                      rd_valid
);

  import io_bridge_pkg::*;

  // Bytes go out MSB first, so the index starts at the top and counts down
  localparam byte_idx_t FIRST_IDX = byte_idx_t'(`IO_BLOCK_BYTES - 1);

  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOAD,
    ST_LOAD_ACK,
    ST_START,
    ST_DONE,
    ST_SEND,
    ST_SEND_ACK
  } state_t;

  state_t      state;
  state_t      next_state;
  buf_target_t target;
  buf_target_t next_target;
  byte_idx_t   idx;
  logic        idx_clear;
  logic        idx_step;

  host_flag_t  req_code;
  host_flag_t  ack_code;
  logic        req_seen;
  logic        ack_seen;
  logic        idle_seen;
  logic        block_end;

  // Key loading runs with the request and acknowledge codes swapped.
  // Readback always uses the message roles.
  assign req_code = (target == TGT_KEY) ? HOST_KEY : HOST_MSG;
  assign ack_code = (target == TGT_KEY) ? HOST_MSG : HOST_KEY;

  assign req_seen  = (to_hw_sig == req_code);
  assign ack_seen  = (to_hw_sig == ack_code);
  assign idle_seen = (to_hw_sig == HOST_IDLE);

  // In an ack state the index has already stepped past the byte just taken.
  // Wrapping back to FIRST_IDX therefore means all 16 bytes are through.
  assign block_end = (idx == FIRST_IDX);

  always_comb begin
    next_state  = state;
    next_target = target;
    idx_clear   = 1'b0;
    idx_step    = 1'b0;

    case (state)
      ST_RESET: begin
        next_state = ST_IDLE;
      end

      ST_IDLE: begin
        case (to_hw_sig)
          HOST_MSG: begin
            next_state  = ST_LOAD;
            next_target = TGT_MSG;
            idx_clear   = 1'b1;
          end
          HOST_KEY: begin
            next_state  = ST_LOAD;
            next_target = TGT_KEY;
            idx_clear   = 1'b1;
          end
          HOST_START: begin
            next_state = ST_START;
          end
          default: begin
            next_state = ST_IDLE;
          end
        endcase
      end

      ST_LOAD: begin
        if (ack_seen) begin
          next_state = ST_LOAD_ACK;
          idx_step   = 1'b1;
        end
      end

      ST_LOAD_ACK: begin
        if (block_end) begin
          if (idle_seen)
            next_state = ST_IDLE;
        end else if (req_seen) begin
          next_state = ST_LOAD;
        end
      end

      // Hold io_ready until the core reports done
      ST_START: begin
        if (aes_ready)
          next_state = ST_DONE;
      end

      // Host may read the result back or skip straight to idle
      ST_DONE: begin
        if (to_hw_sig == HOST_MSG) begin
          next_state  = ST_SEND;
          next_target = TGT_MSG;
          idx_clear   = 1'b1;
        end else if (to_hw_sig == HOST_KEY) begin
          next_state = ST_IDLE;
        end
      end

      ST_SEND: begin
        if (ack_seen) begin
          next_state = ST_SEND_ACK;
          idx_step   = 1'b1;
        end
      end

      ST_SEND_ACK: begin
        if (block_end) begin
          if (idle_seen)
            next_state = ST_IDLE;
        end else if (req_seen) begin
          next_state = ST_SEND;
        end
      end

      default: begin
        next_state = ST_RESET;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state  <= ST_RESET;
      target <= TGT_MSG;
      idx    <= FIRST_IDX;
    end else begin
      state  <= next_state;
      target <= next_target;
      if (idx_clear)
        idx <= FIRST_IDX;
      else if (idx_step)
        idx <= idx - 1'b1;
    end
  end

  // Flag outputs come from the registered state only
  always_comb begin
    case (state)
      ST_RESET: to_sw_sig = HW_RESET;
      ST_LOAD:  to_sw_sig = HW_BUSY;
      ST_SEND:  to_sw_sig = HW_BUSY;
      ST_DONE:  to_sw_sig = HW_DONE;
      default:  to_sw_sig = HW_IDLE;
    endcase
  end

  assign io_ready = (state == ST_START);

  // Byte lands on the same edge as the move to the ack state
  assign byte_wr.en     = (state == ST_LOAD) && ack_seen;
  assign byte_wr.target = target;
  assign byte_wr.idx    = idx;
  assign byte_wr.data   = to_hw_port;

  // Single cycle, since the state leaves ST_START on this edge
  assign result_capture = (state == ST_START) && aes_ready;

  assign rd_idx   = idx;
  assign rd_valid = (state == ST_SEND);

endmodule

//--- block_buffer.sv
`timescale 1ns/1ns

module block_buffer (
  input  logic                     clk,
  input  logic                     reset_n,
  input  io_bridge_pkg::byte_wr_t  byte_wr,
  input  logic                     result_capture,
  input  io_bridge_pkg::block_t    msg_de,
  input  io_bridge_pkg::byte_idx_t rd_idx,
  output io_bridge_pkg::block_t    msg_en,
  output io_bridge_pkg::block_t    key,
  output io_bridge_pkg::byte_t     rd_byte
);

  import io_bridge_pkg::*;

  block_t msg_q;
  block_t key_q;
  block_t result_q;

  logic   msg_we;
  logic   key_we;

  // Steer the write strobe to one of the two input registers
  assign msg_we = byte_wr.en && (byte_wr.target == TGT_MSG);
  assign key_we = byte_wr.en && (byte_wr.target == TGT_KEY);

  // Message register, one byte per host acknowledge
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      msg_q <= '0;
    end else if (msg_we) begin
      msg_q[byte_wr.idx] <= byte_wr.data;
    end
  end

  // Key register, same write path as the message
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      key_q <= '0;
    end else if (key_we) begin
      key_q[byte_wr.idx] <= byte_wr.data;
    end
  end

  // Core output is sampled once when it reports done.
  // Readback then sees a stable copy even if msg_de moves on.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result_q <= '0;
    end else if (result_capture) begin
      result_q <= msg_de;
    end
  end

  assign msg_en = msg_q;
  assign key    = key_q;

  // Combinational byte select for the readback path
  assign rd_byte = result_q[rd_idx];

endmodule

//--- io_bridge.sv
`timescale 1ns/1ns

module io_bridge (
  input  logic                      clk,
  input  logic                      reset_n,

  // Host side
  input  io_bridge_pkg::host_flag_t to_hw_sig,
  input  io_bridge_pkg::byte_t      to_hw_port,
  output io_bridge_pkg::hw_flag_t   to_sw_sig,
  output io_bridge_pkg::byte_t      to_sw_port,

  // Cipher core side
  output io_bridge_pkg::block_t     msg_en,
  output io_bridge_pkg::block_t     key,
  output logic                      io_ready,
  input  io_bridge_pkg::block_t     msg_de,
  input  logic                      aes_ready
);

  import io_bridge_pkg::*;

  byte_wr_t  byte_wr;
  logic      result_capture;
  byte_idx_t rd_idx;
  logic      rd_valid;
  byte_t     rd_byte;

  host_link_ctrl ctrl_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .to_hw_sig      (to_hw_sig),
    .to_hw_port     (to_hw_port),
    .aes_ready      (aes_ready),
    .to_sw_sig      (to_sw_sig),
    .io_ready       (io_ready),
    .byte_wr        (byte_wr),
    .result_capture (result_capture),
    .rd_idx         (rd_idx),
    .rd_valid       (rd_valid)
  );

  block_buffer buf_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .byte_wr        (byte_wr),
    .result_capture (result_capture),
    .msg_de         (msg_de),
    .rd_idx         (rd_idx),
    .msg_en         (msg_en),
    .key            (key),
    .rd_byte        (rd_byte)
  );

  // Port reads zero except while a result byte is on offer
  assign to_sw_port = rd_valid ? rd_byte : '0;

endmodule

//--- tb_io_bridge.sv
`timescale 1ns/1ns
`include "io_bridge_consts.svh"

module tb_io_bridge;

  import io_bridge_pkg::*;

  localparam int NUM_VEC    = 8;
  localparam int WAIT_LIMIT = 40;
  localparam int DRIVE_DLY  = 10;
  localparam logic [31:0] LFSR_SEED = 32'hf15b_9b27;

  logic       clk;
  logic       reset_n;
  host_flag_t to_hw_sig;
  byte_t      to_hw_port;
  hw_flag_t   to_sw_sig;
  byte_t      to_sw_port;
  block_t     msg_en;
  block_t     key;
  logic       io_ready;
  block_t     msg_de;
  logic       aes_ready;

  // Two words per line in the vector file, message then key
  logic [127:0] vec_mem [0:2*NUM_VEC-1];

  logic [31:0] host_lfsr;
  logic [31:0] core_lfsr;
  int          errors;
  int          test_count;
  int          fail_count;
  logic        timed_out;

  io_bridge dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .to_hw_port (to_hw_port),
    .to_sw_sig  (to_sw_sig),
    .to_sw_port (to_sw_port),
    .msg_en     (msg_en),
    .key        (key),
    .io_ready   (io_ready),
    .msg_de     (msg_de),
    .aes_ready  (aes_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Inputs change and outputs are sampled at this point in every cycle
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Zero to three idle cycles, two LFSR bits per draw
  task automatic idle_cycles(inout logic [31:0] st);
    int n;
    n = 0;
    repeat (2) begin
      n = (n << 1) | st[0];
      st = lfsr_next(st);
    end
    repeat (n) next_cycle();
  endtask

  task automatic compare_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input hw_flag_t got, input hw_flag_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0d (%s) expected %0d (%s)",
               $time, name, got, got.name(), exp, exp.name());
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Step first, since the awaited flag never holds on the cycle of the drive
  task automatic wait_flag(input hw_flag_t want, input string what);
    int n;
    n = 0;
    if (timed_out)
      return;
    do begin
      next_cycle();
      n++;
    end while (to_sw_sig !== want && n < WAIT_LIMIT);
    if (to_sw_sig !== want) begin
      $display("Timeout at %0t: to_sw_sig never became %s while %s",
               $time, want.name(), what);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // Host side of a message or key load, key loading swaps the codes
  task automatic load_block(input block_t data, input logic is_key);
    host_flag_t req;
    host_flag_t ack;
    int i;
    req = is_key ? HOST_KEY : HOST_MSG;
    ack = is_key ? HOST_MSG : HOST_KEY;
    to_hw_sig = req;
    for (i = `IO_BLOCK_BYTES - 1; i >= 0; i--) begin
      wait_flag(HW_BUSY, "waiting to send a byte");
      if (timed_out)
        return;
      to_hw_port = data[i];
      to_hw_sig  = ack;
      wait_flag(HW_IDLE, "waiting for a byte to be taken");
      if (timed_out)
        return;
      idle_cycles(host_lfsr);
      to_hw_sig = (i > 0) ? req : HOST_IDLE;
    end
    next_cycle();
  endtask

  task automatic start_cipher();
    int n;
    n = 0;
    to_hw_sig = HOST_START;
    next_cycle();
    to_hw_sig = HOST_IDLE;
    while (to_sw_sig !== HW_DONE && n < WAIT_LIMIT) begin
      compare_bit("io_ready", io_ready, 1'b1);
      compare_flag("to_sw_sig", to_sw_sig, HW_IDLE);
      next_cycle();
      n++;
    end
    if (to_sw_sig !== HW_DONE) begin
      $display("Timeout at %0t: cipher start never reached the done state", $time);
      errors++;
      timed_out = 1'b1;
    end else begin
      compare_bit("io_ready", io_ready, 1'b0);
    end
  endtask

  // Cipher core stand-in, result moves on right after done
  task automatic core_respond(input block_t result);
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (io_ready !== 1'b1 && n < WAIT_LIMIT);
    if (io_ready !== 1'b1) begin
      $display("Timeout at %0t: io_ready never rose for the cipher core", $time);
      errors++;
      timed_out = 1'b1;
      return;
    end
    idle_cycles(core_lfsr);
    next_cycle();
    msg_de    = result;
    aes_ready = 1'b1;
    next_cycle();
    aes_ready = 1'b0;
    msg_de    = ~result;
  endtask

  task automatic read_result(input block_t exp);
    int i;
    to_hw_sig = HOST_MSG;
    for (i = `IO_BLOCK_BYTES - 1; i >= 0; i--) begin
      wait_flag(HW_BUSY, "waiting for a result byte");
      if (timed_out)
        return;
      compare_byte("to_sw_port", to_sw_port, exp[i]);
      to_hw_sig = HOST_KEY;
      wait_flag(HW_IDLE, "waiting after a result byte");
      if (timed_out)
        return;
      compare_byte("to_sw_port", to_sw_port, 8'h00);
      idle_cycles(host_lfsr);
      to_hw_sig = (i > 0) ? HOST_MSG : HOST_IDLE;
    end
    next_cycle();
  endtask

  // One cycle of HOST_KEY only, otherwise idle would start a key load
  task automatic leave_done();
    to_hw_sig = HOST_KEY;
    wait_flag(HW_IDLE, "leaving the done state");
    to_hw_sig = HOST_IDLE;
    compare_bit("io_ready", io_ready, 1'b0);
    next_cycle();
  endtask

  task automatic end_test(input string name, input int vec, input int err_before);
    test_count++;
    if (errors == err_before) begin
      $display("Test %0d %s, vector %0d: passed", test_count, name, vec);
    end else begin
      fail_count++;
      $display("Test %0d %s, vector %0d: FAILED", test_count, name, vec);
    end
  endtask

  initial begin
    int     v;
    int     e;
    block_t msg_v;
    block_t key_v;

    reset_n    = 1'b0;
    to_hw_sig  = HOST_IDLE;
    to_hw_port = '0;
    msg_de     = '0;
    aes_ready  = 1'b0;
    host_lfsr  = LFSR_SEED;
    core_lfsr  = LFSR_SEED;
    errors     = 0;
    test_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;

    $readmemh("io_bridge_patterns.hex", vec_mem);

    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    reset_n = 1'b1;

    // Reset indication lasts one cycle past release
    e = errors;
    compare_flag("to_sw_sig", to_sw_sig, HW_RESET);
    compare_bit("io_ready", io_ready, 1'b0);
    compare_byte("to_sw_port", to_sw_port, 8'h00);
    next_cycle();
    compare_flag("to_sw_sig", to_sw_sig, HW_IDLE);
    compare_bit("io_ready", io_ready, 1'b0);
    next_cycle();
    compare_flag("to_sw_sig", to_sw_sig, HW_IDLE);
    end_test("reset", 0, e);

    if ($isunknown(vec_mem[0]) || $isunknown(vec_mem[2*NUM_VEC-1])) begin
      $display("Could not read the test vectors from io_bridge_patterns.hex");
      errors++;
    end else begin
      for (v = 0; v < NUM_VEC; v++) begin
        msg_v = vec_mem[2*v];
        key_v = vec_mem[2*v+1];

        e = errors;
        load_block(msg_v, 1'b0);
        compare_block("msg_en", msg_en, msg_v);
        end_test("message load", v, e);

        e = errors;
        load_block(key_v, 1'b1);
        compare_block("key", key, key_v);
        compare_block("msg_en", msg_en, msg_v);
        end_test("key load", v, e);

        e = errors;
        fork
          start_cipher();
          core_respond(msg_v ^ key_v);
        join
        end_test("start", v, e);

        e = errors;
        if (v % 4 == 2) begin
          leave_done();
          end_test("leave done", v, e);
        end else begin
          read_result(msg_v ^ key_v);
          end_test("readback", v, e);
        end

        if (timed_out)
          break;
      end
    end

    $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, fail_count, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- io_bridge_patterns.hex
// Columns: message (128 bits, first byte sent is leftmost), key (128 bits)
// Readback is expected to return message XOR key
00112233445566778899aabbccddeeff 000102030405060708090a0b0c0d0e0f
3243f6a8885a308d313198a2e0370734 2b7e151628aed2a6abf7158809cf4f3c
ffffffffffffffffffffffffffffffff 00000000000000000000000000000000
0123456789abcdeffedcba9876543210 0f1e2d3c4b5a69788796a5b4c3d2e1f0
deadbeefcafef00d0badf00d12345678 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c
80000000000000000000000000000001 7fffffffffffffffffffffffffffffff
6bc1bee22e409f96e93d7e117393172a 603deb1015ca71be2b73aef0857d7781
1f2e3d4c5b6a79880011223344556677 c0ffee00badc0ffee1e2e3e4e5e6e7e8

//--- vlog.f
+incdir+.
io_bridge_pkg.sv
host_link_ctrl.sv
block_buffer.sv
io_bridge.sv
tb_io_bridge.sv
